// File: hw/cache_settings.svh
// cache and RAM geometry
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// data cache geometry
`define CACHE_SETS 8
// fixed by the single lru bit per set
`define CACHE_WAYS 2

// backing RAM
`define RAM_WORDS 1024
// wait cycles before each word transfer
`define RAM_LATENCY 2
// reset contents are word address ^ this
`define RAM_SEED_XOR 32'h3c96_0000

`endif

// File: hw/cpu_types_pkg.sv
// cpu word and address types
`default_nettype none

package cpu_types_pkg;

  // one machine word, also the width of every address
  typedef logic [31:0] word_t;

  // address split for the data cache lookup
  typedef struct packed {
    logic [25:0] tag;
    logic [2:0]  idx;     // set select
    logic        blkoff;  // word within the two-word block
    logic [1:0]  bytoff;  // always zero on the bus
  } dcachef_t;

  // same 32 bits seen as a flat word or as lookup fields
  typedef union packed {
    word_t    raw;  // bus side, block alignment
    dcachef_t f;    // cache lookup
  } daddr_u;

endpackage

`default_nettype wire

// File: hw/memory_control.sv
// RAM with wait states and port arbitration
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module memory_control
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // data port
  input  logic  dREN,
  input  logic  dWEN,
  input  word_t daddr,
  input  word_t dstore,
  output logic  dwait,
  output word_t dload,
  // instruction port
  input  logic  iREN,
  input  word_t iaddr,
  output logic  iwait,
  output word_t iload
);
  localparam int AW = $clog2(`RAM_WORDS);
  localparam int CW = $clog2(`RAM_LATENCY + 2);

  word_t ram [`RAM_WORDS];

  logic          dreq, ireq, active, changed, ready;
  logic [2:0]    req, last_req;  // {data read, data write, instr read}
  word_t         gaddr, last_addr;
  logic [CW-1:0] cnt, eff;

  // fixed priority, data port first
  assign dreq   = dREN | dWEN;
  assign ireq   = iREN & ~dreq;
  assign active = dreq | iREN;
  assign req    = {dREN, dWEN, ireq};
  assign gaddr  = dreq ? daddr : iaddr;

  // a new request or address starts the wait over
  assign changed = (req != last_req) || (gaddr != last_addr);
  assign eff     = changed ? '0 : cnt;
  assign ready   = active && (eff == CW'(`RAM_LATENCY));

  assign dwait = dreq & ~ready;
  assign iwait = iREN & (dreq | ~ready);  // held while data traffic is up

  assign dload = ram[daddr[AW+1:2]];
  assign iload = ram[iaddr[AW+1:2]];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      cnt       <= '0;
      last_req  <= '0;
      last_addr <= '0;
    end else begin
      last_req  <= req;
      last_addr <= gaddr;
      if (!active || ready) begin
        cnt <= '0;  // next word waits again
      end else begin
        cnt <= eff + 1'b1;
      end
    end
  end

  // storage, seeded from the word address
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `RAM_WORDS; i++) begin
        ram[i] <= word_t'(i) ^ `RAM_SEED_XOR;
      end
    end else if (dWEN && ready) begin
      ram[daddr[AW+1:2]] <= dstore;  // commits on the transfer cycle
    end
  end

endmodule

`default_nettype wire

// File: hw/dcache.sv
// two-way write-back data cache
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module dcache
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // processor side
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  logic  halt,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  output logic  dhit,
  output logic  flushed,
  output word_t dmemload,
  // memory controller side
  output logic  dREN,
  output logic  dWEN,
  output word_t daddr,
  output word_t dstore,
  input  logic  dwait,
  input  word_t dload,
  // coherence port
  input  logic  ccwait,
  input  logic  ccinv,
  input  word_t ccsnoopaddr,
  output logic  cctrans,
  output logic  ccwrite
);
  localparam int IW = $clog2(`CACHE_SETS);

  localparam logic [3:0] IDLE      = 4'd0;
  localparam logic [3:0] FILL0     = 4'd1;
  localparam logic [3:0] FILL1     = 4'd2;
  localparam logic [3:0] WB0       = 4'd3;
  localparam logic [3:0] WB1       = 4'd4;
  localparam logic [3:0] ALLOC0    = 4'd5;
  localparam logic [3:0] ALLOC1    = 4'd6;
  localparam logic [3:0] FLUSH     = 4'd7;
  localparam logic [3:0] FLUSH_WB0 = 4'd8;
  localparam logic [3:0] FLUSH_WB1 = 4'd9;
  localparam logic [3:0] SNOOP     = 4'd10;
  localparam logic [3:0] DONE      = 4'd11;

  // line storage
  logic [25:0] tags  [`CACHE_WAYS][`CACHE_SETS];
  word_t       data  [`CACHE_WAYS][`CACHE_SETS][2];
  logic        valid [`CACHE_WAYS][`CACHE_SETS];
  logic        dirty [`CACHE_WAYS][`CACHE_SETS];
  logic        lru   [`CACHE_SETS];  // names the way to replace next

  logic [3:0]    state, next_state;
  logic [IW+1:0] cnt, next_cnt;  // flush walk {done, way, set}
  logic          cctrans_n, ccwrite_n;

  daddr_u q, s, blk, wb;  // processor, snoop, fill and write-back addresses

  logic [`CACHE_WAYS-1:0] hit_vec, snoop_vec;
  logic hit, hit_way, victim, wr;
  logic snoop_hit, snoop_way, snoop_dirty;
  logic fetch_word, alloc, flushing, wb_way, wb_word;
  logic [IW-1:0] wb_idx;

  // array update controls from the FSM
  logic  word_we, word_way, word_sel;
  word_t word_val;
  logic  fill_done, fill_dirty, hit_dirty, lru_we, flush_clean, inv_we;

  assign q.raw = dmemaddr;
  assign s.raw = ccsnoopaddr;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_vec[w]   = valid[w][q.f.idx] && (tags[w][q.f.idx] == q.f.tag);
      snoop_vec[w] = valid[w][s.f.idx] && (tags[w][s.f.idx] == s.f.tag);
    end
  end

  assign hit     = |hit_vec;
  assign hit_way = hit_vec[1];
  assign victim  = lru[q.f.idx];
  assign wr      = dmemWEN & ~dmemREN;  // read wins if both are up

  assign snoop_hit   = |snoop_vec;
  assign snoop_way   = snoop_vec[1];
  assign snoop_dirty = (snoop_vec[0] & dirty[0][s.f.idx]) |
                       (snoop_vec[1] & dirty[1][s.f.idx]);

  assign fetch_word = (state == FILL1) || (state == ALLOC1);
  assign alloc      = (state == ALLOC0) || (state == ALLOC1);

  // write-back source is the victim, or the walk position during flush
  assign flushing = (state == FLUSH_WB0) || (state == FLUSH_WB1);
  assign wb_way   = flushing ? cnt[IW] : victim;
  assign wb_idx   = flushing ? cnt[IW-1:0] : q.f.idx;
  assign wb_word  = (state == WB1) || (state == FLUSH_WB1);

  assign flushed = (state == DONE);

  always_comb begin
    next_state = state;
    next_cnt   = cnt;
    cctrans_n  = cctrans;
    ccwrite_n  = ccwrite;

    dhit     = 1'b0;
    dmemload = '0;
    dREN     = 1'b0;
    dWEN     = 1'b0;
    daddr    = '0;
    dstore   = '0;

    word_we     = 1'b0;
    word_way    = victim;
    word_sel    = q.f.blkoff;
    word_val    = dmemstore;
    fill_done   = 1'b0;
    fill_dirty  = 1'b0;
    hit_dirty   = 1'b0;
    lru_we      = 1'b0;
    flush_clean = 1'b0;
    inv_we      = 1'b0;

    blk          = q;
    blk.f.blkoff = fetch_word;
    blk.f.bytoff = '0;

    wb.f.tag    = tags[wb_way][wb_idx];
    wb.f.idx    = wb_idx;
    wb.f.blkoff = wb_word;
    wb.f.bytoff = '0;

    case (state)
      IDLE: begin
        if (ccwait) begin
          next_state = SNOOP;  // snoop beats the processor
        end else if (dmemREN || dmemWEN) begin
          if (hit) begin
            dhit     = 1'b1;
            lru_we   = 1'b1;
            dmemload = data[hit_way][q.f.idx][q.f.blkoff];
            if (wr) begin
              word_we   = 1'b1;
              word_way  = hit_way;
              hit_dirty = 1'b1;
              // clean to modified is a transition
              cctrans_n = ~dirty[hit_way][q.f.idx];
              ccwrite_n = ~dirty[hit_way][q.f.idx];
            end else begin
              cctrans_n = 1'b0;
              ccwrite_n = 1'b0;
            end
          end else if (dirty[victim][q.f.idx]) begin
            next_state = WB0;  // old block goes out first
            cctrans_n  = 1'b0;
            ccwrite_n  = 1'b1;
          end else begin
            next_state = wr ? ALLOC0 : FILL0;
            cctrans_n  = 1'b1;
            ccwrite_n  = wr;
          end
        end else if (halt) begin
          next_state = FLUSH;
          next_cnt   = '0;
        end else begin
          cctrans_n = 1'b0;
          ccwrite_n = 1'b0;
        end
      end

      FILL0, FILL1, ALLOC0, ALLOC1: begin
        dREN     = 1'b1;
        daddr    = blk.raw;
        word_sel = fetch_word;
        // write-allocate merges the store word as the block arrives
        word_val = (alloc && fetch_word == q.f.blkoff) ? dmemstore : dload;
        if (!dwait) begin
          word_we = 1'b1;
          if (fetch_word) begin
            fill_done  = 1'b1;
            fill_dirty = alloc;
            next_state = IDLE;  // retried there as a hit
            cctrans_n  = 1'b0;
            ccwrite_n  = 1'b0;
          end else begin
            next_state = alloc ? ALLOC1 : FILL1;
          end
        end
      end

      WB0, WB1: begin
        dWEN   = 1'b1;
        daddr  = wb.raw;
        dstore = data[wb_way][wb_idx][wb_word];
        if (!dwait) begin
          if (!wb_word) begin
            next_state = WB1;
          end else begin
            next_state = wr ? ALLOC0 : FILL0;
            cctrans_n  = 1'b1;
            ccwrite_n  = wr;
          end
        end
      end

      FLUSH: begin
        if (cnt[IW+1]) begin
          next_state = DONE;  // both ways walked
        end else if (dirty[cnt[IW]][cnt[IW-1:0]]) begin
          next_state = FLUSH_WB0;
        end else begin
          next_cnt = cnt + 1'b1;
        end
      end

      FLUSH_WB0, FLUSH_WB1: begin
        dWEN   = 1'b1;
        daddr  = wb.raw;
        dstore = data[wb_way][wb_idx][wb_word];
        if (!dwait) begin
          if (!wb_word) begin
            next_state = FLUSH_WB1;
          end else begin
            flush_clean = 1'b1;
            next_cnt    = cnt + 1'b1;
            next_state  = FLUSH;
          end
        end
      end

      SNOOP: begin
        if (!ccwait) begin
          next_state = IDLE;
          cctrans_n  = 1'b0;
          ccwrite_n  = 1'b0;
        end
      end

      DONE: next_state = DONE;  // only reset leaves

      default: next_state = IDLE;
    endcase

    // snoop response, both on entry from idle and while held
    if (ccwait && (state == IDLE || state == SNOOP)) begin
      cctrans_n = 1'b1;
      ccwrite_n = snoop_dirty;
      inv_we    = ccinv & snoop_hit;
    end
  end

  // tag and data arrays
  always_ff @(posedge CLK) begin
    if (word_we) begin
      data[word_way][q.f.idx][word_sel] <= word_val;
    end
    if (fill_done) begin
      tags[victim][q.f.idx] <= q.f.tag;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      cnt     <= '0;
      cctrans <= 1'b0;
      ccwrite <= 1'b0;
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        for (int i = 0; i < `CACHE_SETS; i++) begin
          valid[w][i] <= 1'b0;
          dirty[w][i] <= 1'b0;
        end
      end
      for (int i = 0; i < `CACHE_SETS; i++) begin
        lru[i] <= 1'b0;
      end
    end else begin
      state   <= next_state;
      cnt     <= next_cnt;
      cctrans <= cctrans_n;
      ccwrite <= ccwrite_n;
      if (lru_we) begin
        lru[q.f.idx] <= ~hit_way;  // other way goes next
      end
      if (fill_done) begin
        valid[victim][q.f.idx] <= 1'b1;
        dirty[victim][q.f.idx] <= fill_dirty;
      end
      if (hit_dirty) begin
        dirty[hit_way][q.f.idx] <= 1'b1;
      end
      if (flush_clean) begin
        dirty[wb_way][wb_idx] <= 1'b0;
      end
      if (inv_we) begin
        valid[snoop_way][s.f.idx] <= 1'b0;  // hitting way only
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
// data cache with its memory controller
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  // processor port
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  logic  halt,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  output logic  dhit,
  output logic  flushed,
  output word_t dmemload,
  // instruction fetch port
  input  logic  iREN,
  input  word_t iaddr,
  output logic  iwait,
  output word_t iload,
  // coherence port
  input  logic  ccwait,
  input  logic  ccinv,
  input  word_t ccsnoopaddr,
  output logic  cctrans,
  output logic  ccwrite
);
  // cache to controller bus, kept inside
  logic  dREN, dWEN, dwait;
  word_t daddr, dstore, dload;

  dcache dcache0 (
    .CLK(CLK), .nRST(nRST),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dhit(dhit), .flushed(flushed), .dmemload(dmemload),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload),
    .ccwait(ccwait), .ccinv(ccinv), .ccsnoopaddr(ccsnoopaddr),
    .cctrans(cctrans), .ccwrite(ccwrite)
  );

  memory_control memctl0 (
    .CLK(CLK), .nRST(nRST),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload),
    .iREN(iREN), .iaddr(iaddr), .iwait(iwait), .iload(iload)
  );

endmodule

`default_nettype wire

// File: bench/cache_tb_checks.svh
// cache testbench reference model
`ifndef CACHE_TB_CHECKS_SVH
`define CACHE_TB_CHECKS_SVH

  localparam int RAM_AW = $clog2(`RAM_WORDS);

  word_t ref_mem [`RAM_WORDS];  // what the processor should read back
  bit    was_written [`RAM_WORDS];
  word_t written_q [$];         // byte addresses, first write order
  int    err_count = 0;

  function automatic int word_index(input word_t addr);
    return int'(addr[RAM_AW+1:2]);
  endfunction

  function void note_error(input string msg);
    err_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endfunction

  // reset contents, word address xor the seed
  task automatic init_ref_mem();
    for (int i = 0; i < `RAM_WORDS; i++) begin
      ref_mem[i] = word_t'(i) ^ `RAM_SEED_XOR;
    end
  endtask

  task automatic record_write(input word_t addr, input word_t wdata);
    ref_mem[word_index(addr)] = wdata;
    if (!was_written[word_index(addr)]) begin
      was_written[word_index(addr)] = 1'b1;
      written_q.push_back(addr);
    end
  endtask

  read_data_check: assert property (@(posedge CLK) disable iff (!nRST)
    (dhit && dmemREN) |-> dmemload == ref_mem[dmemaddr[RAM_AW+1:2]])
    else note_error($sformatf("read %h returned %h, expected %h",
                              dmemaddr, dmemload, ref_mem[dmemaddr[RAM_AW+1:2]]));

  fetch_data_check: assert property (@(posedge CLK) disable iff (!nRST)
    (iREN && !iwait) |-> iload == ref_mem[iaddr[RAM_AW+1:2]])
    else note_error($sformatf("fetch %h returned %h, expected %h",
                              iaddr, iload, ref_mem[iaddr[RAM_AW+1:2]]));

  // data port owns the RAM while it requests
  fetch_priority_check: assert property (@(posedge CLK) disable iff (!nRST)
    (iREN && (dut0.dREN || dut0.dWEN)) |-> iwait)
    else note_error("iwait low while the cache was using the RAM");

  flushed_hold_check: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |=> flushed)
    else note_error("flushed dropped after it had risen");

`endif

// File: bench/cache_tb.sv
// data cache subsystem testbench
`timescale 1ns/1ps
`default_nettype none
`include "cache_settings.svh"

module cache_tb
  import cpu_types_pkg::*;
();
  localparam int PERIOD      = 100;
  localparam int MISS_CYCLES = 4 * (`RAM_LATENCY + 1) + 2;  // two write-backs, two fetches
  localparam int WAIT_LIMIT  = 4 * MISS_CYCLES;
  localparam int FLUSH_LIMIT = 2 * `CACHE_WAYS * `CACHE_SETS * MISS_CYCLES;
  // six tests, at most 80 accesses each, twice over for margin
  localparam int WATCHDOG_NS = 6 * 80 * MISS_CYCLES * 2 * PERIOD;

  logic  CLK = 1'b0;
  logic  nRST, dmemREN, dmemWEN, halt, dhit, flushed;
  logic  iREN, iwait, ccwait, ccinv, cctrans, ccwrite;
  word_t dmemaddr, dmemstore, dmemload, iaddr, iload, ccsnoopaddr;

  logic [31:0] rng = 32'h1934_f62e;
  int tests_run = 0;
  int tests_failed = 0;

  always #(PERIOD / 2) CLK = ~CLK;

  cache_top dut0 (.*);

  `include "cache_tb_checks.svh"

  function automatic logic [31:0] next_random();
    rng = rng * 32'd1664525 + 32'd1013904223;
    return rng;
  endfunction

  // processor request held until dhit
  task automatic cpu_access(input logic wen, input word_t addr, input word_t wdata,
                            output int cycles);
    logic seen;
    @(negedge CLK);
    dmemREN   = ~wen;
    dmemWEN   = wen;
    dmemaddr  = addr;
    dmemstore = wdata;
    cycles    = 0;
    do begin
      #(PERIOD / 4);  // low phase, well clear of the rising edge
      cycles++;
      seen = dhit;
      @(posedge CLK);
    end while (!seen && cycles < WAIT_LIMIT);
    if (!seen) begin
      err_count++;
      $display("no dhit for address %h within %0d cycles", addr, WAIT_LIMIT);
    end else if (wen) begin
      record_write(addr, wdata);
    end
    @(negedge CLK);
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  task automatic fetch(input word_t addr, output int cycles);
    logic stalled;
    @(negedge CLK);
    iREN   = 1'b1;
    iaddr  = addr;
    cycles = 0;
    do begin
      #(PERIOD / 4);
      cycles++;
      stalled = iwait;
      @(posedge CLK);
    end while (stalled && cycles < WAIT_LIMIT);
    if (stalled) begin
      err_count++;
      $display("instruction read of %h still waiting after %0d cycles", addr, WAIT_LIMIT);
    end
    @(negedge CLK);
    iREN = 1'b0;
  endtask

  // answer is registered, so look one cycle on
  task automatic snoop(input word_t addr, input logic inv, input logic exp_write);
    @(negedge CLK);
    ccwait      = 1'b1;
    ccinv       = inv;
    ccsnoopaddr = addr;
    @(negedge CLK);
    assert (cctrans && ccwrite == exp_write)
      else note_error($sformatf("snoop %h gave cctrans %b ccwrite %b", addr, cctrans, ccwrite));
    ccwait = 1'b0;
    ccinv  = 1'b0;
    @(negedge CLK);
  endtask

  task automatic end_test(input string name, input int start_errs);
    tests_run++;
    if (err_count != start_errs) begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, err_count - start_errs);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("Verification failed");
    $finish;
  end

  initial begin
    int    cycles, dcycles, icycles, start_errs;
    word_t addr, wdata;

    nRST        = 1'b0;
    dmemREN     = 1'b0;
    dmemWEN     = 1'b0;
    halt        = 1'b0;
    dmemaddr    = '0;
    dmemstore   = '0;
    iREN        = 1'b0;
    iaddr       = '0;
    ccwait      = 1'b0;
    ccinv       = 1'b0;
    ccsnoopaddr = '0;
    init_ref_mem();
    repeat (10) @(negedge CLK);
    nRST = 1'b1;
    @(negedge CLK);
    assert (!dhit && !flushed && !cctrans && !ccwrite && !iwait)
      else note_error("outputs not idle after reset");

    start_errs = err_count;
    cpu_access(1'b0, 32'h200, '0, cycles);
    assert (cycles > 1) else note_error("read of a fresh block hit");
    cpu_access(1'b0, 32'h204, '0, cycles);
    assert (cycles == 1) else note_error($sformatf("second block word took %0d cycles", cycles));
    end_test("read miss then block hit", start_errs);

    start_errs = err_count;
    repeat (40) begin
      addr  = next_random();
      addr  = {24'h0, addr[23:18], 2'b00};  // 64 words, four tags per set
      wdata = next_random();
      cpu_access(1'b1, addr, wdata, cycles);
    end
    for (int i = 0; i < written_q.size(); i++) begin
      cpu_access(1'b0, written_q[i], '0, cycles);
    end
    end_test("random writes read back", start_errs);

    start_errs = err_count;
    for (int t = 0; t < 3; t++) begin
      wdata = next_random();
      cpu_access(1'b1, 32'h408 + 32'h40 * t, wdata, cycles);  // all in set 1
    end
    cpu_access(1'b0, 32'h408, '0, cycles);
    assert (cycles > 1) else note_error("evicted line still hit");
    end_test("dirty eviction and refill", start_errs);

    start_errs = err_count;
    wdata = next_random();
    cpu_access(1'b1, 32'h608, wdata, cycles);
    snoop(32'h608, 1'b0, 1'b1);
    snoop(32'h7f0, 1'b0, 1'b0);  // never cached
    cpu_access(1'b0, 32'h610, '0, cycles);
    snoop(32'h610, 1'b1, 1'b0);
    cpu_access(1'b0, 32'h610, '0, cycles);
    assert (cycles > 1) else note_error("invalidated line still hit");
    end_test("snoop and invalidate", start_errs);

    start_errs = err_count;
    fork
      cpu_access(1'b0, 32'h818, '0, dcycles);
      fetch(32'hc40, icycles);
    join
    assert (icycles > dcycles)
      else note_error($sformatf("fetch took %0d cycles, data miss %0d", icycles, dcycles));
    end_test("fetch stalled by data miss", start_errs);

    start_errs = err_count;
    @(negedge CLK);
    halt   = 1'b1;
    cycles = 0;
    do begin
      @(posedge CLK);
      cycles++;
    end while (!flushed && cycles < FLUSH_LIMIT);
    if (!flushed) begin
      err_count++;
      $display("flushed did not rise within %0d cycles of halt", FLUSH_LIMIT);
    end
    repeat (4) @(posedge CLK);
    for (int i = 0; i < written_q.size(); i++) begin
      fetch(written_q[i], cycles);
    end
    end_test("halt flush", start_errs);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
+incdir+bench
hw/cpu_types_pkg.sv
hw/memory_control.sv
hw/dcache.sv
hw/cache_top.sv
bench/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cache_tb -f build.f -o cache_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/cache_sim > sim.log 2>&1
cat sim.log

grep -qx "Verification passed" sim.log \
  && echo "run ok" \
  || { echo "run failed, see sim.log"; exit 1; }
